// File: design/cube_pkg.sv
// Shared widths, opcodes, axis codes and sequencer state for the cube machine.
// Every design and bench file refers to these by cube_pkg:: scoped names.
`default_nettype none

package cube_pkg;

	typedef logic [7:0]  word_t;
	typedef logic [15:0] instr_t;
	typedef logic [7:0]  pc_t;
	typedef logic [3:0]  reg_idx_t;
	typedef logic [3:0]  opcode_t;

	// memory and register file sizes
	localparam int MEM_WORDS = 256;
	localparam int REG_COUNT = 16;

	// opcode field, bits 15..12 of the instruction
	localparam opcode_t OP_LI    = 4'd0;
	localparam opcode_t OP_JMP   = 4'd1;
	localparam opcode_t OP_AND   = 4'd2;
	localparam opcode_t OP_R90   = 4'd3;
	localparam opcode_t OP_R180  = 4'd4;
	localparam opcode_t OP_STORE = 4'd5;
	localparam opcode_t OP_LOAD  = 4'd6;
	localparam opcode_t OP_CHECK = 4'd7;
	localparam opcode_t OP_ZNJ   = 4'd8;
	localparam opcode_t OP_JNZ   = 4'd9;
	localparam opcode_t OP_INC   = 4'd10;
	localparam opcode_t OP_DEC   = 4'd11;
	localparam opcode_t OP_HALT  = 4'd12;

	// rotation axis, carried in field c
	localparam reg_idx_t AXIS_X = 4'd0;
	localparam reg_idx_t AXIS_Y = 4'd1;
	localparam reg_idx_t AXIS_Z = 4'd2;

	// corner coordinate bits inside a word
	// twist sits in 1..0, spare bits in 7..5
	localparam int CORNER_X_BIT = 4;
	localparam int CORNER_Y_BIT = 3;
	localparam int CORNER_Z_BIT = 2;

	typedef enum logic {
		IDLE,
		RUN
	} seq_state_e;

endpackage

`default_nettype wire

// File: design/prog_mem.sv
// 256-word instruction RAM, host write port and combinational fetch port.
`timescale 1ns/10ps
`default_nettype none

module prog_mem (
	input  wire                clk,
	input  wire                we,
	input  cube_pkg::pc_t      waddr,
	input  cube_pkg::instr_t   wdata,
	input  cube_pkg::pc_t      raddr,
	output cube_pkg::instr_t   rdata
);

	cube_pkg::instr_t mem [cube_pkg::MEM_WORDS];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	assign rdata = mem[raddr];

endmodule

`default_nettype wire

// File: design/data_mem.sv
// 256-byte data RAM with an execution port and a host read port.
// Both reads are combinational, the write is clocked.
`timescale 1ns/10ps
`default_nettype none

module data_mem (
	input  wire               clk,
	input  wire               we,
	input  cube_pkg::word_t   addr,
	input  cube_pkg::word_t   wdata,
	output cube_pkg::word_t   rdata,
	input  cube_pkg::word_t   host_addr,
	output cube_pkg::word_t   host_data
);

	cube_pkg::word_t mem [cube_pkg::MEM_WORDS];

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
	end

	assign rdata     = mem[addr];
	assign host_data = mem[host_addr];

endmodule

`default_nettype wire

// File: design/reg_file.sv
// Sixteen 8-bit registers, two combinational read ports, one clocked write port.
`timescale 1ns/10ps
`default_nettype none

module reg_file (
	input  wire                 clk,
	input  wire                 rst_n,
	input  cube_pkg::reg_idx_t  ra_idx,
	input  cube_pkg::reg_idx_t  rb_idx,
	output cube_pkg::word_t     ra_data,
	output cube_pkg::word_t     rb_data,
	input  wire                 we,
	input  cube_pkg::reg_idx_t  wr_idx,
	input  cube_pkg::word_t     wr_data
);

	cube_pkg::word_t regs [cube_pkg::REG_COUNT];

	assign ra_data = regs[ra_idx];
	assign rb_data = regs[rb_idx];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < cube_pkg::REG_COUNT; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[wr_idx] <= wr_data;
		end
	end

endmodule

`default_nettype wire

// File: design/cube_alu.sv
// Combinational ALU: AND, corner quarter and half turns, increment, decrement.
// Rotations touch only the x/y/z bits of the word on port b.
`timescale 1ns/10ps
`default_nettype none

module cube_alu (
	input  cube_pkg::opcode_t   op,
	input  cube_pkg::reg_idx_t  axis,
	input  cube_pkg::word_t     a,
	input  cube_pkg::word_t     b,
	output cube_pkg::word_t     result
);

	logic            x;
	logic            y;
	logic            z;
	cube_pkg::word_t quarter;
	cube_pkg::word_t half;

	assign x = b[cube_pkg::CORNER_X_BIT];
	assign y = b[cube_pkg::CORNER_Y_BIT];
	assign z = b[cube_pkg::CORNER_Z_BIT];

	always_comb begin
		quarter = b;
		half    = b;
		case (axis)
			cube_pkg::AXIS_X: begin
				quarter[cube_pkg::CORNER_Y_BIT] = z;
				quarter[cube_pkg::CORNER_Z_BIT] = ~y;
				half[cube_pkg::CORNER_Y_BIT]    = ~y;
				half[cube_pkg::CORNER_Z_BIT]    = ~z;
			end
			cube_pkg::AXIS_Y: begin
				quarter[cube_pkg::CORNER_Z_BIT] = x;
				quarter[cube_pkg::CORNER_X_BIT] = ~z;
				half[cube_pkg::CORNER_Z_BIT]    = ~z;
				half[cube_pkg::CORNER_X_BIT]    = ~x;
			end
			cube_pkg::AXIS_Z: begin
				quarter[cube_pkg::CORNER_X_BIT] = y;
				quarter[cube_pkg::CORNER_Y_BIT] = ~x;
				half[cube_pkg::CORNER_X_BIT]    = ~x;
				half[cube_pkg::CORNER_Y_BIT]    = ~y;
			end
			// unknown axis leaves the corner where it is
			default: ;
		endcase
	end

	always_comb begin
		case (op)
			cube_pkg::OP_AND:  result = a & b;
			cube_pkg::OP_R90:  result = quarter;
			cube_pkg::OP_R180: result = half;
			cube_pkg::OP_INC:  result = a + 8'd1;
			cube_pkg::OP_DEC:  result = a - 8'd1;
			default:           result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/cube_seq.sv
// Sequencer: program counter, decode, equal flag and the idle/run FSM.
// Executes one instruction per clock in RUN and pulses done on HALT.
`timescale 1ns/10ps
`default_nettype none

module cube_seq (
	input  wire                 clk,
	input  wire                 rst_n,
	input  wire                 start,
	input  cube_pkg::instr_t    instr,
	output cube_pkg::pc_t       pc,
	output logic                busy,
	output logic                done,
	output cube_pkg::reg_idx_t  ra_idx,
	output cube_pkg::reg_idx_t  rb_idx,
	input  cube_pkg::word_t     ra_data,
	output cube_pkg::opcode_t   alu_op,
	output cube_pkg::reg_idx_t  alu_axis,
	input  cube_pkg::word_t     alu_result,
	input  cube_pkg::word_t     mem_rdata,
	output logic                mem_we,
	output logic                reg_we,
	output cube_pkg::reg_idx_t  wr_idx,
	output cube_pkg::word_t     wr_data
);

	cube_pkg::seq_state_e state;
	cube_pkg::opcode_t    op;
	cube_pkg::reg_idx_t   field_a;
	cube_pkg::reg_idx_t   field_b;
	cube_pkg::reg_idx_t   field_c;
	cube_pkg::word_t      imm;
	logic                 eq_flag;
	logic                 take_jump;
	logic                 running;

	assign op      = instr[15:12];
	assign field_a = instr[11:8];
	assign field_b = instr[7:4];
	assign field_c = instr[3:0];
	assign imm     = instr[7:0];

	assign running = (state == cube_pkg::RUN);
	assign busy    = running;
	assign done    = running && (op == cube_pkg::OP_HALT);

	// CHECK compares reg[a], everything else reads reg[c] on port a
	assign ra_idx   = (op == cube_pkg::OP_CHECK) ? field_a : field_c;
	assign rb_idx   = field_b;
	assign alu_op   = op;
	assign alu_axis = field_c;
	assign wr_idx   = field_a;

	always_comb begin
		case (op)
			cube_pkg::OP_JMP: take_jump = 1'b1;
			cube_pkg::OP_ZNJ: take_jump = ~eq_flag;
			cube_pkg::OP_JNZ: take_jump = eq_flag;
			default:          take_jump = 1'b0;
		endcase
	end

	// write-back source and strobes
	always_comb begin
		reg_we  = 1'b0;
		mem_we  = 1'b0;
		wr_data = alu_result;
		case (op)
			cube_pkg::OP_LI: begin
				reg_we  = running;
				wr_data = imm;
			end
			cube_pkg::OP_LOAD: begin
				reg_we  = running;
				wr_data = mem_rdata;
			end
			cube_pkg::OP_AND,
			cube_pkg::OP_R90,
			cube_pkg::OP_R180,
			cube_pkg::OP_INC,
			cube_pkg::OP_DEC: reg_we = running;
			cube_pkg::OP_STORE: mem_we = running;
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= cube_pkg::IDLE;
			pc      <= '0;
			eq_flag <= 1'b0;
		end else begin
			case (state)
				cube_pkg::IDLE: begin
					if (start) begin
						state <= cube_pkg::RUN;
						pc    <= '0;
					end
				end
				cube_pkg::RUN: begin
					if (op == cube_pkg::OP_HALT)
						state <= cube_pkg::IDLE;
					else if (take_jump)
						pc <= imm;
					else
						pc <= pc + 8'd1;
					if (op == cube_pkg::OP_CHECK)
						eq_flag <= (ra_data == imm);
				end
				default: state <= cube_pkg::IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/cube_top.sv
// Top level of the cube register machine.
// Host loads program memory, pulses start, waits for done, then reads data memory.
`timescale 1ns/10ps
`default_nettype none

module cube_top (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                prog_we,
	input  cube_pkg::pc_t      prog_addr,
	input  cube_pkg::instr_t   prog_data,
	input  wire                start,
	output logic               busy,
	output logic               done,
	input  cube_pkg::word_t    rd_addr,
	output cube_pkg::word_t    rd_data
);

	cube_pkg::pc_t      pc;
	cube_pkg::instr_t   instr;
	cube_pkg::reg_idx_t ra_idx;
	cube_pkg::reg_idx_t rb_idx;
	cube_pkg::word_t    ra_data;
	cube_pkg::word_t    rb_data;
	cube_pkg::opcode_t  alu_op;
	cube_pkg::reg_idx_t alu_axis;
	cube_pkg::word_t    alu_result;
	cube_pkg::word_t    mem_rdata;
	logic               mem_we;
	logic               reg_we;
	cube_pkg::reg_idx_t wr_idx;
	cube_pkg::word_t    wr_data;
	logic               prog_wr_en;

	// host cannot rewrite the program under a running sequencer
	assign prog_wr_en = prog_we & ~busy;

	cube_seq seq_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.instr      (instr),
		.pc         (pc),
		.busy       (busy),
		.done       (done),
		.ra_idx     (ra_idx),
		.rb_idx     (rb_idx),
		.ra_data    (ra_data),
		.alu_op     (alu_op),
		.alu_axis   (alu_axis),
		.alu_result (alu_result),
		.mem_rdata  (mem_rdata),
		.mem_we     (mem_we),
		.reg_we     (reg_we),
		.wr_idx     (wr_idx),
		.wr_data    (wr_data)
	);

	reg_file reg_file_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.ra_idx  (ra_idx),
		.rb_idx  (rb_idx),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.we      (reg_we),
		.wr_idx  (wr_idx),
		.wr_data (wr_data)
	);

	cube_alu alu_i (
		.op     (alu_op),
		.axis   (alu_axis),
		.a      (ra_data),
		.b      (rb_data),
		.result (alu_result)
	);

	prog_mem prog_mem_i (
		.clk   (clk),
		.we    (prog_wr_en),
		.waddr (prog_addr),
		.wdata (prog_data),
		.raddr (pc),
		.rdata (instr)
	);

	// store/load address from reg[b], store data from reg[c]
	data_mem data_mem_i (
		.clk       (clk),
		.we        (mem_we),
		.addr      (rb_data),
		.wdata     (ra_data),
		.rdata     (mem_rdata),
		.host_addr (rd_addr),
		.host_data (rd_data)
	);

endmodule

`default_nettype wire

// File: bench/tb_tasks.svh
// Program build, run, readback and compare tasks plus the directed tests.
// Included inside the tb_cube module body.
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic tick();
	@(posedge clk);
	#DRIVE_DELAY;
endtask

function automatic cube_pkg::instr_t enc(cube_pkg::opcode_t op, int a, int b, int c);
	return {op, 4'(a), 4'(b), 4'(c)};
endfunction

function automatic cube_pkg::instr_t enc_imm(cube_pkg::opcode_t op, int a,
		cube_pkg::word_t imm);
	return {op, 4'(a), imm};
endfunction

// r15 holds the address, r14 the value
task automatic mark(cube_pkg::word_t addr, cube_pkg::word_t val);
	prog.push_back(enc_imm(cube_pkg::OP_LI, 15, addr));
	prog.push_back(enc_imm(cube_pkg::OP_LI, 14, val));
	prog.push_back(enc(cube_pkg::OP_STORE, 0, 15, 14));
endtask

task automatic store_reg(int r, cube_pkg::word_t addr);
	prog.push_back(enc_imm(cube_pkg::OP_LI, 15, addr));
	prog.push_back(enc(cube_pkg::OP_STORE, 0, 15, r));
endtask

task automatic load_prog();
	foreach (prog[i]) begin
		prog_we   = 1'b1;
		prog_addr = cube_pkg::pc_t'(i);
		prog_data = prog[i];
		tick();
	end
	prog_we = 1'b0;
endtask

// pulse start, wait for done, let the FSM drop back to idle
task automatic run_prog(output int cycles);
	start = 1'b1;
	tick();
	start  = 1'b0;
	cycles = 1;
	while (!done) begin
		tick();
		cycles++;
	end
	tick();
endtask

task automatic read_mem(cube_pkg::word_t addr, output cube_pkg::word_t val);
	rd_addr = addr;
	#1;
	val = rd_data;
endtask

task automatic check_word(string what, cube_pkg::word_t exp, cube_pkg::word_t act);
	if (act !== exp) begin
		$display("mismatch %s %s: expected %02h, actual %02h", test_name, what, exp, act);
		test_errors++;
		errors++;
	end
endtask

task automatic check_flag(string what, logic exp, logic act);
	if (act !== exp) begin
		$display("mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
		test_errors++;
		errors++;
	end
endtask

task automatic check_mem(cube_pkg::word_t addr, cube_pkg::word_t exp);
	cube_pkg::word_t got;
	read_mem(addr, got);
	check_word($sformatf("mem[%02h]", addr), exp, got);
endtask

task automatic begin_test(string name);
	test_name   = name;
	test_errors = 0;
	prog.delete();
endtask

task automatic end_test();
	tests_run++;
	if (test_errors == 0) begin
		$display("PASS %s", test_name);
	end else begin
		tests_failed++;
		$display("FAIL %s with %0d errors", test_name, test_errors);
	end
endtask

// expected corner turns, worked out on the x, y, z coordinates
function automatic cube_pkg::word_t turn_quarter(cube_pkg::word_t w, int axis);
	cube_pkg::word_t r;
	logic x;
	logic y;
	logic z;
	{x, y, z} = w[4:2];
	case (axis)
		0: {y, z} = {z, ~y};
		1: {z, x} = {x, ~z};
		2: {x, y} = {y, ~x};
		default: ;
	endcase
	r      = w;
	r[4:2] = {x, y, z};
	return r;
endfunction

function automatic cube_pkg::word_t turn_half(cube_pkg::word_t w, int axis);
	cube_pkg::word_t r;
	r = w;
	case (axis)
		0: r[3:2] = ~w[3:2];
		1: r = w ^ 8'h14;
		2: r[4:3] = ~w[4:3];
		default: ;
	endcase
	return r;
endfunction

task automatic run_control_test();
	localparam int N = 6;
	int cycles;
	int dones;
	int first;
	begin_test("run_control");
	check_flag("busy after reset", 1'b0, busy);
	check_flag("done after reset", 1'b0, done);
	for (int i = 0; i < N; i++)
		prog.push_back(enc_imm(cube_pkg::OP_LI, i + 1, cube_pkg::word_t'(i)));
	prog.push_back(enc(cube_pkg::OP_HALT, 0, 0, 0));
	load_prog();
	dones = 0;
	first = 0;
	start = 1'b1;
	tick();
	start = 1'b0;
	check_flag("busy in run", 1'b1, busy);
	cycles = 1;
	// second start at cycle 2 lands while busy
	while (cycles < 24) begin
		if (done) begin
			dones++;
			if (first == 0)
				first = cycles;
		end
		start = (cycles == 2);
		tick();
		cycles++;
	end
	start = 1'b0;
	check_word("done count", 8'd1, cube_pkg::word_t'(dones));
	check_word("start to done", cube_pkg::word_t'(N + 1), cube_pkg::word_t'(first));
	check_flag("busy at end", 1'b0, busy);
	end_test();
endtask

task automatic load_store_test();
	cube_pkg::word_t addrs[4];
	cube_pkg::word_t vals[4];
	int cycles;
	begin_test("load_store");
	for (int i = 0; i < 4; i++) begin
		addrs[i] = {6'($urandom()), 2'(i)};
		vals[i]  = 8'($urandom());
		mark(addrs[i], vals[i]);
	end
	prog.push_back(enc(cube_pkg::OP_HALT, 0, 0, 0));
	load_prog();
	run_prog(cycles);
	// straight line ending in halt, so N+1 is the program size
	check_word("start to done", cube_pkg::word_t'(prog.size()), cube_pkg::word_t'(cycles));
	for (int i = 0; i < 4; i++)
		check_mem(addrs[i], vals[i]);
	end_test();
endtask

task automatic arith_test();
	cube_pkg::word_t a;
	cube_pkg::word_t b;
	int cycles;
	begin_test("arith");
	a = 8'($urandom());
	b = 8'($urandom());
	prog.push_back(enc_imm(cube_pkg::OP_LI, 1, a));
	prog.push_back(enc_imm(cube_pkg::OP_LI, 2, b));
	prog.push_back(enc(cube_pkg::OP_AND, 3, 1, 2));
	prog.push_back(enc_imm(cube_pkg::OP_LI, 4, 8'hff));
	prog.push_back(enc(cube_pkg::OP_INC, 5, 0, 4));
	prog.push_back(enc_imm(cube_pkg::OP_LI, 6, 8'h00));
	prog.push_back(enc(cube_pkg::OP_DEC, 7, 0, 6));
	prog.push_back(enc(cube_pkg::OP_INC, 8, 0, 1));
	prog.push_back(enc(cube_pkg::OP_DEC, 9, 0, 2));
	store_reg(3, 8'h10);
	store_reg(5, 8'h11);
	store_reg(7, 8'h12);
	store_reg(8, 8'h13);
	store_reg(9, 8'h14);
	prog.push_back(enc(cube_pkg::OP_HALT, 0, 0, 0));
	load_prog();
	run_prog(cycles);
	check_word("start to done", cube_pkg::word_t'(prog.size()), cube_pkg::word_t'(cycles));
	check_mem(8'h10, a & b);
	check_mem(8'h11, 8'h00);
	check_mem(8'h12, 8'hff);
	check_mem(8'h13, a + 8'd1);
	check_mem(8'h14, b - 8'd1);
	end_test();
endtask

task automatic rotation_test();
	cube_pkg::word_t w[3];
	int cycles;
	begin_test("rotation");
	for (int ax = 0; ax < 3; ax++) begin
		w[ax] = 8'($urandom());
		prog.push_back(enc_imm(cube_pkg::OP_LI, 1, w[ax]));
		prog.push_back(enc(cube_pkg::OP_R90, 2, 1, ax));
		prog.push_back(enc(cube_pkg::OP_R180, 3, 1, ax));
		prog.push_back(enc(cube_pkg::OP_R90, 4, 1, ax));
		for (int k = 0; k < 3; k++)
			prog.push_back(enc(cube_pkg::OP_R90, 4, 4, ax));
		store_reg(2, cube_pkg::word_t'(8'h20 + ax * 4));
		store_reg(3, cube_pkg::word_t'(8'h21 + ax * 4));
		store_reg(4, cube_pkg::word_t'(8'h22 + ax * 4));
	end
	prog.push_back(enc(cube_pkg::OP_HALT, 0, 0, 0));
	load_prog();
	run_prog(cycles);
	check_word("start to done", cube_pkg::word_t'(prog.size()), cube_pkg::word_t'(cycles));
	for (int ax = 0; ax < 3; ax++) begin
		check_mem(cube_pkg::word_t'(8'h20 + ax * 4), turn_quarter(w[ax], ax));
		check_mem(cube_pkg::word_t'(8'h21 + ax * 4), turn_half(w[ax], ax));
		check_mem(cube_pkg::word_t'(8'h22 + ax * 4), w[ax]);
	end
	end_test();
endtask

task automatic branch_test();
	int j1;
	int j2;
	int j3;
	int j4;
	int j5;
	int cycles;
	begin_test("branch");
	mark(8'h50, 8'h00);
	mark(8'h51, 8'h00);
	mark(8'h52, 8'h00);
	mark(8'h43, 8'h00);
	prog.push_back(enc_imm(cube_pkg::OP_LI, 1, 8'h5a));
	prog.push_back(enc_imm(cube_pkg::OP_CHECK, 1, 8'h5a));
	j1 = prog.size();
	prog.push_back('0);
	mark(8'h40, 8'h11);
	j2 = prog.size();
	prog.push_back('0);
	mark(8'h50, 8'he1);
	prog[j2] = enc_imm(cube_pkg::OP_JNZ, 0, 8'(prog.size()));
	prog.push_back(enc_imm(cube_pkg::OP_CHECK, 1, 8'h00));
	j3 = prog.size();
	prog.push_back('0);
	mark(8'h41, 8'h22);
	j4 = prog.size();
	prog.push_back('0);
	mark(8'h51, 8'he2);
	prog[j4] = enc_imm(cube_pkg::OP_ZNJ, 0, 8'(prog.size()));
	j5 = prog.size();
	prog.push_back('0);
	mark(8'h52, 8'he3);
	prog[j5] = enc_imm(cube_pkg::OP_JMP, 0, 8'(prog.size()));
	mark(8'h42, 8'h33);
	prog.push_back(enc(cube_pkg::OP_HALT, 0, 0, 0));
	// wrongly taken branches land here
	prog[j1] = enc_imm(cube_pkg::OP_ZNJ, 0, 8'(prog.size()));
	prog[j3] = enc_imm(cube_pkg::OP_JNZ, 0, 8'(prog.size()));
	mark(8'h43, 8'hbb);
	prog.push_back(enc(cube_pkg::OP_HALT, 0, 0, 0));
	load_prog();
	run_prog(cycles);
	// 29 instructions on the correct path before halt
	check_word("start to done", 8'd30, cube_pkg::word_t'(cycles));
	check_mem(8'h40, 8'h11);
	check_mem(8'h41, 8'h22);
	check_mem(8'h42, 8'h33);
	check_mem(8'h43, 8'h00);
	check_mem(8'h50, 8'h00);
	check_mem(8'h51, 8'h00);
	check_mem(8'h52, 8'h00);
	end_test();
endtask

task automatic load_copy_test();
	cube_pkg::word_t v;
	int cycles;
	begin_test("load_copy");
	v = 8'($urandom());
	mark(8'h60, v);
	// r3 starts as the complement so a missed load shows
	prog.push_back(enc_imm(cube_pkg::OP_LI, 3, ~v));
	prog.push_back(enc_imm(cube_pkg::OP_LI, 1, 8'h60));
	prog.push_back(enc(cube_pkg::OP_LOAD, 3, 1, 0));
	store_reg(3, 8'h61);
	prog.push_back(enc(cube_pkg::OP_HALT, 0, 0, 0));
	load_prog();
	run_prog(cycles);
	check_word("start to done", cube_pkg::word_t'(prog.size()), cube_pkg::word_t'(cycles));
	check_mem(8'h60, v);
	check_mem(8'h61, v);
	end_test();
endtask

`endif

// File: bench/tb_cube.sv
// Testbench for the cube register machine: clock, reset, DUT, watchdog and report.
// Directed tests live in the included task header and run in sequence below.
`timescale 1ns/10ps
`default_nettype none

module tb_cube;

	// longest test runs under 64 instructions plus program load and readback,
	// so a few hundred cycles per test covers all six with wide margin
	localparam int TIMEOUT_CYCLES = 5000;
	localparam int DRIVE_DELAY = 2;

	logic                clk;
	logic                rst_n;
	logic                prog_we;
	cube_pkg::pc_t       prog_addr;
	cube_pkg::instr_t    prog_data;
	logic                start;
	logic                busy;
	logic                done;
	cube_pkg::word_t     rd_addr;
	cube_pkg::word_t     rd_data;

	int                  cycle_count;
	int                  errors;
	int                  test_errors;
	int                  tests_run;
	int                  tests_failed;
	string               test_name;
	cube_pkg::instr_t    prog[$];

	cube_top cube_top_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.start     (start),
		.busy      (busy),
		.done      (done),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

	`include "tb_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// watchdog
	initial cycle_count = 0;
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: simulation ran past %0d cycles without finishing",
				TIMEOUT_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h1bd0_29d6));
		rst_n        = 1'b0;
		prog_we      = 1'b0;
		prog_addr    = '0;
		prog_data    = '0;
		start        = 1'b0;
		rd_addr      = '0;
		errors       = 0;
		test_errors  = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_name    = "";
		repeat (5) @(posedge clk);
		#DRIVE_DELAY rst_n = 1'b1;
		tick();

		run_control_test();
		load_store_test();
		arith_test();
		rotation_test();
		branch_test();
		load_copy_test();

		$display("tests run %0d, tests failed %0d, errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+bench
design/cube_pkg.sv
design/prog_mem.sv
design/data_mem.sv
design/reg_file.sv
design/cube_alu.sv
design/cube_seq.sv
design/cube_top.sv
bench/tb_cube.sv

// File: run.sh
#!/bin/sh
# Build and run the cube machine testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f filelist.f --top-module tb_cube -o sim_cube

./obj_dir/sim_cube | tee sim.log

if grep -q "Test failures found" sim.log; then
	echo "simulation reported failures"
	exit 1
fi
echo "simulation clean"
exit 0
